/* source/lb_pkg.sv */
/*
 * Shared definitions of the hash-based load balancer
 *   Sizes of interfaces, cores, slots, tags and buffers
 *   Host register codes and reset values
 *   Packed struct types for hashes, decisions, host commands and slot status
 */

`default_nettype none

package lb_pkg;

  // Sizes
  localparam int IF_COUNT        = 3;
  localparam int CORE_COUNT      = 8;
  localparam int CORE_ID_WIDTH   = 3;
  localparam int IF_ID_WIDTH     = 2;
  localparam int SLOT_WIDTH      = 6;
  localparam int TAG_WIDTH       = 6;
  localparam int ID_TAG_WIDTH    = CORE_ID_WIDTH + TAG_WIDTH;
  localparam int RX_LINES_WIDTH  = 13;
  localparam int HASH_SEL_OFFSET = 14;
  localparam int HASH_FIFO_DEPTH = 16;

  // Index of the last interface, wrap point of the round-robin search
  localparam logic [IF_ID_WIDTH-1:0] IF_LAST = IF_ID_WIDTH'(IF_COUNT - 1);

  // Reset and readback values
  localparam logic [RX_LINES_WIDTH-1:0] DROP_LIMIT_RESET = 13'd3584;
  localparam logic [31:0]               READ_DEFAULT     = 32'hFEFEFEFE;

  // Core register codes
  localparam logic [3:0] REG_ENABLED    = 4'd0;
  localparam logic [3:0] REG_INCOME     = 4'd1;
  localparam logic [3:0] REG_FLUSH      = 4'd2;
  localparam logic [3:0] REG_SLOT_COUNT = 4'd3;
  // Interface register codes
  localparam logic [3:0] REG_DROP_COUNT = 4'd2;
  localparam logic [3:0] REG_DROP_LIMIT = 4'd3;

  typedef logic [CORE_COUNT-1:0] core_mask_t;

  // Flow hash as delivered by a receive interface
  typedef struct packed {
    logic [3:0]  hash_type;
    logic [31:0] hash;
  } hash_entry_t;

  // Drop bit, hash and descriptor (core id in the upper bits, tag below)
  typedef struct packed {
    logic                    drop;
    logic [31:0]             hash;
    logic [ID_TAG_WIDTH-1:0] desc;
  } decision_t;

  // Register code in addr[3:0], core or interface index from addr[4]
  typedef struct packed {
    logic        wr_en;
    logic        for_ints;
    logic [28:0] addr;
    logic [31:0] wr_data;
  } host_cmd_t;

  typedef struct packed {
    logic [SLOT_WIDTH-1:0] count;
    logic                  valid;
    logic                  busy;
  } slot_status_t;

endpackage

`default_nettype wire

/* source/flow_fifo.sv */
/*
 * flow_fifo
 *   Synchronous FIFO with first-word-fall-through head
 *   Entry type given as a type parameter, DEPTH a power of two
 */

`default_nettype none

module flow_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 16
) (
  input  wire    clk,
  input  wire    rst,
  input  wire    push,
  input  entry_t din,
  output logic   full,
  output entry_t dout,
  output logic   dout_valid,
  input  wire    pop
);

  // Storage, no reset needed
  entry_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;

  logic do_push;
  logic do_pop;

  // Writes into a full FIFO and reads from an empty one are ignored
  assign do_push = push && !full;
  assign do_pop  = pop && dout_valid;

  assign full       = (count == DEPTH);
  assign dout_valid = (count != '0);
  // Head shown before the pop
  assign dout       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/port_arbiter.sv */
/*
 * port_arbiter
 *   Same-cycle round-robin arbiter over the receive interfaces
 *   Search starts after the last winner, kept in a register
 */

`default_nettype none

module port_arbiter (
  input  wire                                clk,
  input  wire                                rst,
  input  wire  [lb_pkg::IF_COUNT-1:0]        request,
  output logic [lb_pkg::IF_COUNT-1:0]        grant,
  output logic                               grant_valid,
  output logic [lb_pkg::IF_ID_WIDTH-1:0]     grant_index
);

  logic [lb_pkg::IF_ID_WIDTH-1:0] last_index;

  // First requester after the last winner, wrapping at the last interface
  always_comb begin
    logic [lb_pkg::IF_ID_WIDTH-1:0] idx;
    idx         = last_index;
    grant       = '0;
    grant_valid = 1'b0;
    grant_index = '0;
    for (int i = 0; i < lb_pkg::IF_COUNT; i++) begin
      idx = (idx == lb_pkg::IF_LAST) ? '0 : idx + 1'b1;
      if (!grant_valid && request[idx]) begin
        grant[idx]  = 1'b1;
        grant_valid = 1'b1;
        grant_index = idx;
      end
    end
  end

  // Interface 0 has first priority after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      last_index <= lb_pkg::IF_LAST;
    end else if (grant_valid) begin
      last_index <= grant_index;
    end
  end

endmodule

`default_nettype wire

/* source/host_regs.sv */
/*
 * host_regs
 *   Host command decode for core and interface registers
 *   Enabled and incoming core masks, one-cycle slot flush pulse
 *   Drop limit, per-interface drop counters and registered readback
 */

`default_nettype none

module host_regs (
  input  wire                                              clk,
  input  wire                                              rst,
  input  lb_pkg::host_cmd_t                                host_cmd,
  output logic [31:0]                                      host_rd_data,
  output lb_pkg::core_mask_t                               enabled_cores,
  output lb_pkg::core_mask_t                               income_cores,
  output lb_pkg::core_mask_t                               slots_flush,
  output logic [lb_pkg::RX_LINES_WIDTH-1:0]                drop_limit,
  input  lb_pkg::slot_status_t [lb_pkg::CORE_COUNT-1:0]    slot_status,
  input  wire                                              drop_strobe,
  input  wire  [lb_pkg::IF_ID_WIDTH-1:0]                   drop_if
);

  logic [3:0]                        reg_code;
  logic [lb_pkg::CORE_ID_WIDTH-1:0]  core_sel;
  logic [lb_pkg::IF_ID_WIDTH-1:0]    if_sel;
  lb_pkg::core_mask_t                wr_mask;

  logic [lb_pkg::IF_COUNT-1:0][31:0] drop_count;

  // Address fields
  assign reg_code = host_cmd.addr[3:0];
  assign core_sel = host_cmd.addr[4 +: lb_pkg::CORE_ID_WIDTH];
  assign if_sel   = host_cmd.addr[4 +: lb_pkg::IF_ID_WIDTH];
  assign wr_mask  = host_cmd.wr_data[lb_pkg::CORE_COUNT-1:0];

  //////////////////////////////////////////////////////////////////////
  // Configuration writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
      drop_limit    <= lb_pkg::DROP_LIMIT_RESET;
    end else begin
      // Flush is a pulse, cleared unless written this cycle
      slots_flush <= '0;
      if (host_cmd.wr_en && !host_cmd.for_ints) begin
        case (reg_code)
          lb_pkg::REG_ENABLED: begin
            // A disabled core cannot stay incoming
            enabled_cores <= wr_mask;
            income_cores  <= income_cores & wr_mask;
          end
          lb_pkg::REG_INCOME: begin
            income_cores <= wr_mask & enabled_cores;
          end
          lb_pkg::REG_FLUSH: begin
            slots_flush <= wr_mask;
          end
          default: begin
          end
        endcase
      end else if (host_cmd.wr_en && host_cmd.for_ints) begin
        if (reg_code == lb_pkg::REG_DROP_LIMIT) begin
          drop_limit <= host_cmd.wr_data[lb_pkg::RX_LINES_WIDTH-1:0];
        end
      end
    end
  end

  // One counter per interface, bumped by the allocator on each drop
  always_ff @(posedge clk) begin
    if (rst) begin
      drop_count <= '0;
    end else if (drop_strobe) begin
      drop_count[drop_if] <= drop_count[drop_if] + 32'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Readback, one cycle after the address
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    host_rd_data <= lb_pkg::READ_DEFAULT;
    if (!host_cmd.for_ints) begin
      case (reg_code)
        lb_pkg::REG_ENABLED:    host_rd_data <= 32'(enabled_cores);
        lb_pkg::REG_INCOME:     host_rd_data <= 32'(income_cores);
        lb_pkg::REG_SLOT_COUNT: host_rd_data <= 32'(slot_status[core_sel].count);
        default: begin
        end
      endcase
    end else if (reg_code == lb_pkg::REG_DROP_COUNT && if_sel < lb_pkg::IF_COUNT) begin
      // Indexes past the last interface stay at the default
      host_rd_data <= drop_count[if_sel];
    end
  end

endmodule

`default_nettype wire

/* source/desc_allocator.sv */
/*
 * desc_allocator
 *   Request build and round-robin arbitration over the hash FIFO heads
 *   Registered grant and target core taken from the hash
 *   Almost-full flags from the buffer fill counts
 *   Allocate, drop or wait decision and descriptor pop
 */

`default_nettype none

module desc_allocator (
  input  wire                                              clk,
  input  wire                                              rst,
  // Hash FIFO heads
  input  lb_pkg::hash_entry_t [lb_pkg::IF_COUNT-1:0]       head,
  input  wire  [lb_pkg::IF_COUNT-1:0]                      head_valid,
  output logic [lb_pkg::IF_COUNT-1:0]                      head_pop,
  // Decision FIFOs
  input  wire  [lb_pkg::IF_COUNT-1:0]                      dec_full,
  output logic [lb_pkg::IF_COUNT-1:0]                      dec_push,
  output lb_pkg::decision_t                                dec_entry,
  // Buffer state and configuration
  input  wire  [lb_pkg::IF_COUNT-1:0][lb_pkg::RX_LINES_WIDTH-1:0] line_count,
  input  wire  [lb_pkg::RX_LINES_WIDTH-1:0]                drop_limit,
  input  lb_pkg::core_mask_t                               income_cores,
  input  lb_pkg::slot_status_t [lb_pkg::CORE_COUNT-1:0]    slot_status,
  // Core controller
  output logic [lb_pkg::CORE_ID_WIDTH-1:0]                 selected_core,
  output logic                                             desc_pop,
  input  wire  [lb_pkg::ID_TAG_WIDTH-1:0]                  desc_data,
  // Drop reporting
  output logic                                             drop_strobe,
  output logic [lb_pkg::IF_ID_WIDTH-1:0]                   drop_if
);

  logic [lb_pkg::IF_COUNT-1:0]    request;
  logic [lb_pkg::IF_COUNT-1:0]    grant;
  logic                           grant_valid;
  logic [lb_pkg::IF_ID_WIDTH-1:0] grant_index;

  // Grant held for the decision cycle
  logic [lb_pkg::IF_COUNT-1:0]    grant_r;
  logic                           grant_valid_r;
  logic [lb_pkg::IF_ID_WIDTH-1:0] grant_index_r;

  logic [lb_pkg::IF_COUNT-1:0]    almost_full;
  logic                           core_busy;
  logic                           core_avail;

  //////////////////////////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////////////////////////

  // No request right after a grant, the decision is still pending
  // No request either when the decision FIFO has no room
  assign request = head_valid & ~grant_r & ~dec_full;

  port_arbiter arb0 (
    .clk         (clk),
    .rst         (rst),
    .request     (request),
    .grant       (grant),
    .grant_valid (grant_valid),
    .grant_index (grant_index)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_r       <= '0;
      grant_valid_r <= 1'b0;
      grant_index_r <= '0;
      selected_core <= '0;
    end else begin
      grant_r       <= grant;
      grant_valid_r <= grant_valid;
      grant_index_r <= grant_index;
      // Target core from a fixed bit field of the winner's hash
      selected_core <= head[grant_index].hash[lb_pkg::HASH_SEL_OFFSET +: lb_pkg::CORE_ID_WIDTH];
    end
  end

  // Fill level at or above the host limit, one cycle late
  always_ff @(posedge clk) begin
    if (rst) begin
      almost_full <= '0;
    end else begin
      for (int i = 0; i < lb_pkg::IF_COUNT; i++) begin
        almost_full[i] <= (line_count[i] >= drop_limit);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decision
  //////////////////////////////////////////////////////////////////////

  // Core status for the registered selection
  assign core_busy  = slot_status[selected_core].busy;
  assign core_avail = slot_status[selected_core].valid & income_cores[selected_core];

  // Entry goes only to the FIFO whose push is raised
  assign dec_entry.drop = !core_avail;
  assign dec_entry.hash = head[grant_index_r].hash;
  assign dec_entry.desc = desc_data;

  assign drop_if = grant_index_r;

  always_comb begin
    desc_pop    = 1'b0;
    head_pop    = '0;
    dec_push    = '0;
    drop_strobe = 1'b0;
    // Busy core, nothing happens and the interface asks again
    if (grant_valid_r && !core_busy) begin
      if (core_avail) begin
        desc_pop = 1'b1;
        head_pop = grant_r;
        dec_push = grant_r;
      end else if (almost_full[grant_index_r]) begin
        // Buffer too full to wait, drop without taking a descriptor
        head_pop    = grant_r;
        dec_push    = grant_r;
        drop_strobe = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/lb_hash_dropping.sv */
/*
 * lb_hash_dropping
 *   Top level of the load balancer control path
 *   Per-interface hash and decision FIFOs
 *   Descriptor allocator and host register block
 */

`default_nettype none

module lb_hash_dropping (
  input  wire                                                     clk,
  input  wire                                                     rst,
  // Receive interfaces
  input  lb_pkg::hash_entry_t [lb_pkg::IF_COUNT-1:0]              hash_in,
  input  wire  [lb_pkg::IF_COUNT-1:0]                             hash_valid,
  input  wire  [lb_pkg::IF_COUNT-1:0][lb_pkg::RX_LINES_WIDTH-1:0] line_count,
  // Decisions out
  output lb_pkg::decision_t [lb_pkg::IF_COUNT-1:0]                dec_out,
  output logic [lb_pkg::IF_COUNT-1:0]                             dec_valid,
  input  wire  [lb_pkg::IF_COUNT-1:0]                             dec_ready,
  // Host
  input  lb_pkg::host_cmd_t                                       host_cmd,
  output logic [31:0]                                             host_rd_data,
  output lb_pkg::core_mask_t                                      enabled_cores,
  output lb_pkg::core_mask_t                                      slots_flush,
  input  lb_pkg::slot_status_t [lb_pkg::CORE_COUNT-1:0]           slot_status,
  // Core controller
  output logic [lb_pkg::CORE_ID_WIDTH-1:0]                        selected_core,
  output logic                                                    desc_pop,
  input  wire  [lb_pkg::ID_TAG_WIDTH-1:0]                         desc_data
);

  lb_pkg::hash_entry_t [lb_pkg::IF_COUNT-1:0] head;
  logic [lb_pkg::IF_COUNT-1:0]                head_valid;
  logic [lb_pkg::IF_COUNT-1:0]                head_pop;

  logic [lb_pkg::IF_COUNT-1:0]                dec_full;
  logic [lb_pkg::IF_COUNT-1:0]                dec_push;
  lb_pkg::decision_t                          dec_entry;

  lb_pkg::core_mask_t                         income_cores;
  logic [lb_pkg::RX_LINES_WIDTH-1:0]          drop_limit;
  logic                                       drop_strobe;
  logic [lb_pkg::IF_ID_WIDTH-1:0]             drop_if;

  //////////////////////////////////////////////////////////////////////
  // Per-interface FIFOs
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < lb_pkg::IF_COUNT; i++) begin : g_if
    // Hash source keeps within the FIFO depth, full not watched
    flow_fifo #(
      .entry_t (lb_pkg::hash_entry_t),
      .DEPTH   (lb_pkg::HASH_FIFO_DEPTH)
    ) hash_fifo (
      .clk        (clk),
      .rst        (rst),
      .push       (hash_valid[i]),
      .din        (hash_in[i]),
      .full       (),
      .dout       (head[i]),
      .dout_valid (head_valid[i]),
      .pop        (head_pop[i])
    );

    // Drop bit, hash and descriptor waiting for the consumer
    flow_fifo #(
      .entry_t (lb_pkg::decision_t),
      .DEPTH   (lb_pkg::HASH_FIFO_DEPTH)
    ) dec_fifo (
      .clk        (clk),
      .rst        (rst),
      .push       (dec_push[i]),
      .din        (dec_entry),
      .full       (dec_full[i]),
      .dout       (dec_out[i]),
      .dout_valid (dec_valid[i]),
      .pop        (dec_ready[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Allocation and host registers
  //////////////////////////////////////////////////////////////////////

  desc_allocator alloc0 (
    .clk           (clk),
    .rst           (rst),
    .head          (head),
    .head_valid    (head_valid),
    .head_pop      (head_pop),
    .dec_full      (dec_full),
    .dec_push      (dec_push),
    .dec_entry     (dec_entry),
    .line_count    (line_count),
    .drop_limit    (drop_limit),
    .income_cores  (income_cores),
    .slot_status   (slot_status),
    .selected_core (selected_core),
    .desc_pop      (desc_pop),
    .desc_data     (desc_data),
    .drop_strobe   (drop_strobe),
    .drop_if       (drop_if)
  );

  host_regs regs0 (
    .clk           (clk),
    .rst           (rst),
    .host_cmd      (host_cmd),
    .host_rd_data  (host_rd_data),
    .enabled_cores (enabled_cores),
    .income_cores  (income_cores),
    .slots_flush   (slots_flush),
    .drop_limit    (drop_limit),
    .slot_status   (slot_status),
    .drop_strobe   (drop_strobe),
    .drop_if       (drop_if)
  );

endmodule

`default_nettype wire

/* sim/lb_checker.sv */
/*
 * lb_checker
 *   Concurrent assertions on the descriptor allocator
 *   Descriptor pop only for a valid, incoming and idle core
 *   No push into a full decision FIFO, no pop of an empty hash FIFO
 *   One-hot arbiter grant, bound into every desc_allocator
 */

`default_nettype none

module lb_checker (
  input  wire                                              clk,
  input  wire                                              rst,
  input  wire                                              desc_pop,
  input  wire  [lb_pkg::CORE_ID_WIDTH-1:0]                 selected_core,
  input  lb_pkg::slot_status_t [lb_pkg::CORE_COUNT-1:0]    slot_status,
  input  lb_pkg::core_mask_t                               income_cores,
  input  wire  [lb_pkg::IF_COUNT-1:0]                      dec_push,
  input  wire  [lb_pkg::IF_COUNT-1:0]                      dec_full,
  input  wire  [lb_pkg::IF_COUNT-1:0]                      head_pop,
  input  wire  [lb_pkg::IF_COUNT-1:0]                      head_valid,
  input  wire  [lb_pkg::IF_COUNT-1:0]                      grant
);
  timeunit 1ns;
  timeprecision 1ps;

  // Descriptor taken only from a core that can accept the packet
  a_pop_core_ready: assert property (@(posedge clk) disable iff (rst)
    desc_pop |-> (slot_status[selected_core].valid && income_cores[selected_core]
                  && !slot_status[selected_core].busy))
    else $error("Descriptor pop for core %0d that cannot take it", selected_core);

  // Decision FIFO overflow would lose a decision
  a_push_room: assert property (@(posedge clk) disable iff (rst)
    (dec_push & dec_full) == '0)
    else $error("Decision push into a full FIFO, push %b full %b", dec_push, dec_full);

  a_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
    (head_pop & ~head_valid) == '0)
    else $error("Hash pop from an empty FIFO, pop %b valid %b", head_pop, head_valid);

  // At most one interface wins per cycle
  a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant))
    else $error("Arbiter grant not one-hot, grant %b", grant);

endmodule

bind desc_allocator lb_checker chk0 (
  .clk           (clk),
  .rst           (rst),
  .desc_pop      (desc_pop),
  .selected_core (selected_core),
  .slot_status   (slot_status),
  .income_cores  (income_cores),
  .dec_push      (dec_push),
  .dec_full      (dec_full),
  .head_pop      (head_pop),
  .head_valid    (head_valid),
  .grant         (grant)
);

`default_nettype wire

/* sim/tb_lb_hash_dropping.sv */
/*
 * Testbench of the load balancer control path
 *   Clock, reset, hash and host stimulus on the falling edge
 *   Core-controller model with one tag counter per core
 *   Reference decision function, expected queues and compare process
 */

`default_nettype none

module tb_lb_hash_dropping;
  timeunit 1ns;
  timeprecision 1ps;

  logic                                                    clk = 1'b0;
  logic                                                    rst = 1'b1;
  lb_pkg::hash_entry_t [lb_pkg::IF_COUNT-1:0]              hash_in = '0;
  logic [lb_pkg::IF_COUNT-1:0]                             hash_valid = '0;
  logic [lb_pkg::IF_COUNT-1:0][lb_pkg::RX_LINES_WIDTH-1:0] line_count = '0;
  lb_pkg::decision_t [lb_pkg::IF_COUNT-1:0]                dec_out;
  logic [lb_pkg::IF_COUNT-1:0]                             dec_valid;
  logic [lb_pkg::IF_COUNT-1:0]                             dec_ready = '1;
  lb_pkg::host_cmd_t                                       host_cmd = '0;
  logic [31:0]                                             host_rd_data;
  lb_pkg::core_mask_t                                      enabled_cores;
  lb_pkg::core_mask_t                                      slots_flush;
  lb_pkg::slot_status_t [lb_pkg::CORE_COUNT-1:0]           slot_status = '0;
  logic [lb_pkg::CORE_ID_WIDTH-1:0]                        selected_core;
  logic                                                    desc_pop;
  logic [lb_pkg::ID_TAG_WIDTH-1:0]                         desc_data;

  // Tag counters of the core model and their prediction
  logic [lb_pkg::CORE_COUNT-1:0][lb_pkg::TAG_WIDTH-1:0]    model_tag;
  logic [lb_pkg::CORE_COUNT-1:0][lb_pkg::TAG_WIDTH-1:0]    pred_tag;
  lb_pkg::core_mask_t                                      exp_income;
  logic [lb_pkg::RX_LINES_WIDTH-1:0]                       exp_limit;
  lb_pkg::decision_t                                       exp_q [lb_pkg::IF_COUNT][$];
  lb_pkg::hash_entry_t                                     held_q [lb_pkg::IF_COUNT][$];
  int                                                      pop_count;
  int                                                      alloc_expected;
  // 0 always ready, 1 never ready, 2 random
  int                                                      ready_mode = 0;

  lb_hash_dropping dut0 (
    .clk           (clk),
    .rst           (rst),
    .hash_in       (hash_in),
    .hash_valid    (hash_valid),
    .line_count    (line_count),
    .dec_out       (dec_out),
    .dec_valid     (dec_valid),
    .dec_ready     (dec_ready),
    .host_cmd      (host_cmd),
    .host_rd_data  (host_rd_data),
    .enabled_cores (enabled_cores),
    .slots_flush   (slots_flush),
    .slot_status   (slot_status),
    .selected_core (selected_core),
    .desc_pop      (desc_pop),
    .desc_data     (desc_data)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Core-controller model and consumer
  //////////////////////////////////////////////////////////////////////

  // Descriptor is core id over the core's current tag
  assign desc_data = {selected_core, model_tag[selected_core]};

  always @(posedge clk) begin
    if (rst) begin
      model_tag <= '0;
      pop_count <= 0;
    end else if (desc_pop) begin
      model_tag[selected_core] <= model_tag[selected_core] + 6'd1;
      pop_count <= pop_count + 1;
    end
  end

  always @(negedge clk) begin
    for (int i = 0; i < lb_pkg::IF_COUNT; i++) begin
      case (ready_mode)
        1:       dec_ready[i] = 1'b0;
        2:       dec_ready[i] = ($urandom % 3) != 0;
        default: dec_ready[i] = 1'b1;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_failed();
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_decision(input string name, input lb_pkg::decision_t got,
                                input lb_pkg::decision_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_mask(input string name, input lb_pkg::core_mask_t got,
                            input lb_pkg::core_mask_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      stop_failed();
    end
  endtask

  // Every transfer must match the head of its interface's queue
  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < lb_pkg::IF_COUNT; i++) begin
        if (dec_valid[i] && dec_ready[i]) begin
          if (exp_q[i].size() == 0) begin
            $display("Decision on interface %0d when none was expected", i);
            stop_failed();
          end else begin
            check_decision($sformatf("dec_out[%0d]", i), dec_out[i], exp_q[i].pop_front());
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Returns 0 when the hash has to wait at the head of its FIFO
  function automatic logic expected_decision(
    input  lb_pkg::hash_entry_t                                  h,
    input  lb_pkg::core_mask_t                                   income,
    input  lb_pkg::slot_status_t [lb_pkg::CORE_COUNT-1:0]        status,
    input  logic                                                 almost_full,
    input  logic [lb_pkg::CORE_COUNT-1:0][lb_pkg::TAG_WIDTH-1:0] tags,
    output lb_pkg::decision_t                                    d
  );
    logic [2:0] core;
    // Target core from hash bits 16 to 14
    core   = h.hash[16:14];
    d.hash = h.hash;
    d.desc = {core, tags[core]};
    d.drop = 1'b0;
    if (status[core].busy) begin
      return 1'b0;
    end
    if (status[core].valid && income[core]) begin
      return 1'b1;
    end
    // Not incoming, dropped only when the buffer is nearly full
    d.drop = 1'b1;
    return almost_full;
  endfunction

  task automatic predict(input int i, input lb_pkg::hash_entry_t h);
    lb_pkg::decision_t d;
    logic              ok;
    logic [2:0]        core;
    ok = expected_decision(h, exp_income, slot_status, line_count[i] >= exp_limit,
                           pred_tag, d);
    // A waiting head blocks everything behind it
    if (ok && held_q[i].size() == 0) begin
      exp_q[i].push_back(d);
      core = d.desc[8:6];
      if (!d.drop) begin
        pred_tag[core] = pred_tag[core] + 6'd1;
        alloc_expected++;
      end
    end else begin
      held_q[i].push_back(h);
    end
  endtask

  // Re-evaluate waiting hashes after the state changed
  task automatic resolve_held();
    lb_pkg::hash_entry_t waiting [$];
    for (int i = 0; i < lb_pkg::IF_COUNT; i++) begin
      waiting = held_q[i];
      held_q[i].delete();
      foreach (waiting[k]) begin
        predict(i, waiting[k]);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic send_one(input int i, input logic [2:0] core);
    lb_pkg::hash_entry_t h;
    h.hash        = $urandom;
    h.hash_type   = 4'($urandom);
    h.hash[16:14] = core;
    @(negedge clk);
    hash_in[i]    = h;
    hash_valid    = '0;
    hash_valid[i] = 1'b1;
    predict(i, h);
    @(negedge clk);
    hash_valid = '0;
  endtask

  // Interface i only targets cores i, i+3 and i+6, so each core has one source
  task automatic send_burst(input int n);
    logic [2:0] core;
    for (int k = 0; k < 3 * n; k++) begin
      core = 3'((k % 3) + 3 * ($urandom % ((k % 3 == 2) ? 2 : 3)));
      send_one(k % 3, core);
    end
  endtask

  task automatic host_write(input logic for_ints, input logic [3:0] code,
                            input int idx, input logic [31:0] data);
    @(negedge clk);
    host_cmd.wr_en    = 1'b1;
    host_cmd.for_ints = for_ints;
    host_cmd.addr     = (29'(idx) << 4) | 29'(code);
    host_cmd.wr_data  = data;
    @(negedge clk);
    host_cmd.wr_en = 1'b0;
  endtask

  // Readback is registered, data one cycle after the address
  task automatic read_check(input logic for_ints, input logic [3:0] code,
                            input int idx, input logic [31:0] exp);
    @(negedge clk);
    host_cmd.wr_en    = 1'b0;
    host_cmd.for_ints = for_ints;
    host_cmd.addr     = (29'(idx) << 4) | 29'(code);
    @(negedge clk);
    check_word("host_rd_data", host_rd_data, exp);
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < lb_pkg::IF_COUNT; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (pending() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > 2000) begin
        $display("Timed out waiting for %0d expected decisions", pending());
        stop_failed();
      end
    end
  endtask

  // Held hashes must not produce any decision
  task automatic check_quiet(input int n);
    for (int k = 0; k < n; k++) begin
      @(negedge clk);
      if (dec_valid != '0) begin
        $display("A decision appeared while its hash should wait");
        stop_failed();
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h38fa));
    pred_tag       = '0;
    alloc_expected = 0;
    exp_income     = '0;
    exp_limit      = 13'd3584;
    for (int c = 0; c < lb_pkg::CORE_COUNT; c++) begin
      slot_status[c].count = 6'(c * 7 + 2);
      slot_status[c].valid = 1'b1;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // After reset
    @(negedge clk);
    check_mask("enabled_cores", enabled_cores, 8'h00);
    check_mask("slots_flush", slots_flush, 8'h00);
    check_word("dec_valid", 32'(dec_valid), 32'h0);
    read_check(1'b0, 4'd7, 0, 32'hFEFEFEFE);
    read_check(1'b1, 4'd0, 0, 32'hFEFEFEFE);
    read_check(1'b1, lb_pkg::REG_DROP_COUNT, 3, 32'hFEFEFEFE);
    for (int i = 0; i < lb_pkg::IF_COUNT; i++) begin
      read_check(1'b1, lb_pkg::REG_DROP_COUNT, i, 32'h0);
    end

    // Register rules
    host_write(1'b0, lb_pkg::REG_ENABLED, 0, 32'h3C);
    check_mask("enabled_cores", enabled_cores, 8'h3C);
    host_write(1'b0, lb_pkg::REG_INCOME, 0, 32'hFF);
    read_check(1'b0, lb_pkg::REG_INCOME, 0, 32'h3C);
    host_write(1'b0, lb_pkg::REG_ENABLED, 0, 32'h0C);
    read_check(1'b0, lb_pkg::REG_INCOME, 0, 32'h0C);
    host_write(1'b0, lb_pkg::REG_FLUSH, 0, 32'hA5);
    check_mask("slots_flush", slots_flush, 8'hA5);
    @(negedge clk);
    check_mask("slots_flush", slots_flush, 8'h00);
    read_check(1'b0, lb_pkg::REG_SLOT_COUNT, 5, 32'd37);

    // Allocation on all cores
    host_write(1'b0, lb_pkg::REG_ENABLED, 0, 32'hFF);
    host_write(1'b0, lb_pkg::REG_INCOME, 0, 32'hFF);
    exp_income = 8'hFF;
    send_burst(12);
    wait_drained();
    check_word("desc_pop count", 32'(pop_count), 32'(alloc_expected));

    // Dropping above the limit with no incoming core
    host_write(1'b0, lb_pkg::REG_INCOME, 0, 32'h00);
    exp_income = 8'h00;
    host_write(1'b1, lb_pkg::REG_DROP_LIMIT, 0, 32'd100);
    exp_limit = 13'd100;
    line_count = {3{13'd200}};
    repeat (2) @(negedge clk);
    send_burst(5);
    wait_drained();
    for (int i = 0; i < lb_pkg::IF_COUNT; i++) begin
      read_check(1'b1, lb_pkg::REG_DROP_COUNT, i, 32'd5);
    end

    // Below the limit the hashes wait for an incoming core
    line_count = {3{13'd50}};
    repeat (2) @(negedge clk);
    send_burst(2);
    check_quiet(30);
    host_write(1'b0, lb_pkg::REG_INCOME, 0, 32'hFF);
    exp_income = 8'hFF;
    resolve_held();
    wait_drained();

    // Busy core holds its hashes
    slot_status[3].busy = 1'b1;
    for (int k = 0; k < 3; k++) begin
      send_one(0, 3'd3);
    end
    check_quiet(20);
    slot_status[3].busy = 1'b0;
    resolve_held();
    wait_drained();

    // Back-pressure, decision FIFOs fill then drain at random
    ready_mode = 1;
    send_burst(20);
    ready_mode = 2;
    wait_drained();
    ready_mode = 0;
    check_quiet(5);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/lb_pkg.sv
source/flow_fifo.sv
source/port_arbiter.sv
source/host_regs.sv
source/desc_allocator.sv
source/lb_hash_dropping.sv
sim/lb_checker.sv
sim/tb_lb_hash_dropping.sv

/* Makefile */
# Verilator build and run of the load balancer testbench
TOP = tb_lb_hash_dropping

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | awk '{ print } /TESTBENCH PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
